// ==== design/oam_dma_macros.svh ====
`ifndef OAM_DMA_MACROS_SVH
`define OAM_DMA_MACROS_SVH

// ==========================================================
// address map
// ==========================================================

// dma source page register
`define DMA_REG_ADDR 16'hFF46
// object attribute memory window
`define OAM_BASE 16'hFE00
// bytes moved per transfer, FE00 to FE9F
`define OAM_LEN 8'd160
// work ram window, C000 to DFFF
`define WRAM_BASE 16'hC000
`define WRAM_ADDR_BITS 13
`define OAM_ADDR_BITS 8

// read values for unmapped and refused accesses
`define OPEN_BUS 8'h9F
`define BLOCKED_READ 8'hFF

`endif

// ==== design/bus_pkg.sv ====
package bus_pkg;

  // ==========================================================
  // cpu side request
  // ==========================================================

  // read_en and write_en are single cycle strobes
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        read_en;
    logic        write_en;
  } cpu_req_t;

  // ==========================================================
  // memory port request
  // ==========================================================

  // same layout as the cpu request
  // driven by the dma engine or by the arbiter toward a ram
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        read_en;
    logic        write_en;
  } mem_req_t;

endpackage

// ==== design/dma_pkg.sv ====
package dma_pkg;

  // per byte copy sequence, one cycle each
  // read     read strobe on the port
  // latch    source byte back, write strobe set up
  // settle   write strobe on the port
  // done     index step or end of transfer
  typedef enum logic [1:0] {
    PH_READ,
    PH_LATCH,
    PH_SETTLE,
    PH_WRITE_DONE
  } dma_phase_t;

endpackage

// four phases per byte
// 160 bytes, 640 cycles

// ==== design/byte_ram.sv ====
`timescale 1ns/100ps

// single port byte ram
// read data registered, one cycle behind the strobe
module byte_ram #(
  parameter int ADDR_BITS = 8
) (
  input  logic              clk,
  input  bus_pkg::mem_req_t req,
  output logic [7:0]        rdata
);

  localparam int DEPTH = 1 << ADDR_BITS;

  logic [7:0]           mem [DEPTH];
  logic [ADDR_BITS-1:0] index;

  // window offset from the low address bits
  assign index = req.addr[ADDR_BITS-1:0];

  always_ff @(posedge clk) begin
    if (req.write_en) begin
      mem[index] <= req.wdata;
    end
    // rdata holds between reads
    if (req.read_en) begin
      rdata <= mem[index];
    end
  end

endmodule

// ==== design/oam_dma_engine.sv ====
`timescale 1ns/100ps

`include "oam_dma_macros.svh"

module oam_dma_engine (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  logic [7:0]        start_page,
  output logic [7:0]        source_page,
  output logic              busy,
  output bus_pkg::mem_req_t dma_req,
  input  logic [7:0]        dma_rdata
);

  // control state
  logic [7:0]          page_q;
  logic [7:0]          index_q;
  logic                busy_q;
  dma_pkg::dma_phase_t phase_q;
  logic                rd_q;
  logic                wr_q;

  // port payload
  logic [15:0] addr_q;
  logic [7:0]  wdata_q;

  logic        last_byte;
  logic [7:0]  next_index;
  logic [15:0] dst_addr;

  assign last_byte  = (index_q == (`OAM_LEN - 8'd1));
  assign next_index = index_q + 8'd1;
  // destination is oam base plus byte index
  assign dst_addr   = `OAM_BASE + {8'h00, index_q};

  // ==========================================================
  // sequencer
  // ==========================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      page_q  <= 8'h00;
      index_q <= 8'd0;
      busy_q  <= 1'b0;
      phase_q <= dma_pkg::PH_READ;
      rd_q    <= 1'b0;
      wr_q    <= 1'b0;
    end else if (start) begin
      // new page, also restarts a running transfer
      page_q  <= start_page;
      index_q <= 8'd0;
      busy_q  <= 1'b1;
      phase_q <= dma_pkg::PH_READ;
      rd_q    <= 1'b1;
      wr_q    <= 1'b0;
    end else if (busy_q) begin
      unique case (phase_q)
        dma_pkg::PH_READ: begin
          // read sampled by the ram this cycle
          rd_q    <= 1'b0;
          phase_q <= dma_pkg::PH_LATCH;
        end
        dma_pkg::PH_LATCH: begin
          wr_q    <= 1'b1;
          phase_q <= dma_pkg::PH_SETTLE;
        end
        dma_pkg::PH_SETTLE: begin
          // oam takes the byte at the end of this cycle
          wr_q    <= 1'b0;
          phase_q <= dma_pkg::PH_WRITE_DONE;
        end
        dma_pkg::PH_WRITE_DONE: begin
          phase_q <= dma_pkg::PH_READ;
          if (last_byte) begin
            busy_q  <= 1'b0;
            index_q <= 8'd0;
          end else begin
            // next byte read goes out right away
            index_q <= next_index;
            rd_q    <= 1'b1;
          end
        end
      endcase
    end
  end

  // ==========================================================
  // address and data toward the port
  // ==========================================================
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= {start_page, 8'h00};
    end else if (busy_q && (phase_q == dma_pkg::PH_LATCH)) begin
      // source byte is on dma_rdata now
      addr_q  <= dst_addr;
      wdata_q <= dma_rdata;
    end else if (busy_q && (phase_q == dma_pkg::PH_WRITE_DONE)) begin
      addr_q <= {page_q, next_index};
    end
  end

  assign dma_req.addr     = addr_q;
  assign dma_req.wdata    = wdata_q;
  assign dma_req.read_en  = rd_q;
  assign dma_req.write_en = wr_q;

  assign source_page = page_q;
  assign busy        = busy_q;

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/100ps

`include "oam_dma_macros.svh"

module mem_arbiter (
  input  logic              clk,
  input  logic              reset,
  input  bus_pkg::cpu_req_t cpu,
  output logic [7:0]        cpu_rdata,
  output logic              start,
  output logic [7:0]        start_page,
  input  logic [7:0]        source_page,
  input  logic              busy,
  input  bus_pkg::mem_req_t dma_req,
  output logic [7:0]        dma_rdata,
  output bus_pkg::mem_req_t wram_req,
  input  logic [7:0]        wram_rdata,
  output bus_pkg::mem_req_t oam_req,
  input  logic [7:0]        oam_rdata
);

  // one past the last byte of each window
  localparam logic [16:0] WRAM_END = {1'b0, `WRAM_BASE} + (17'd1 << `WRAM_ADDR_BITS);
  localparam logic [16:0] OAM_END  = {1'b0, `OAM_BASE} + {9'd0, `OAM_LEN};

  function automatic logic in_wram(input logic [15:0] addr);
    return (addr >= `WRAM_BASE) && ({1'b0, addr} < WRAM_END);
  endfunction

  function automatic logic in_oam(input logic [15:0] addr);
    return (addr >= `OAM_BASE) && ({1'b0, addr} < OAM_END);
  endfunction

  logic              cpu_dma_reg;
  logic              cpu_ram;
  bus_pkg::mem_req_t owner_req;
  logic [7:0]        hold_q;
  logic              wram_pend_q;
  logic              oam_pend_q;
  logic              dma_wram_hit_q;
  logic              dma_oam_hit_q;

  // ==========================================================
  // cpu decode
  // ==========================================================
  assign cpu_dma_reg = (cpu.addr == `DMA_REG_ADDR);
  assign cpu_ram     = in_wram(cpu.addr) || in_oam(cpu.addr);
  // register write stays live during a transfer
  assign start       = cpu.write_en && cpu_dma_reg;
  assign start_page  = cpu.wdata;

  // engine owns the port for the whole transfer
  assign owner_req = busy ? dma_req : bus_pkg::mem_req_t'(cpu);

  always_comb begin
    wram_req          = owner_req;
    wram_req.read_en  = owner_req.read_en && in_wram(owner_req.addr);
    wram_req.write_en = owner_req.write_en && in_wram(owner_req.addr);
    oam_req           = owner_req;
    oam_req.read_en   = owner_req.read_en && in_oam(owner_req.addr);
    oam_req.write_en  = owner_req.write_en && in_oam(owner_req.addr);
  end

  // ==========================================================
  // read data return
  // ==========================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hold_q         <= 8'h00;
      wram_pend_q    <= 1'b0;
      oam_pend_q     <= 1'b0;
      dma_wram_hit_q <= 1'b0;
      dma_oam_hit_q  <= 1'b0;
    end else begin
      wram_pend_q <= 1'b0;
      oam_pend_q  <= 1'b0;
      // keep ram data once the ram moves on
      if (wram_pend_q || oam_pend_q)
        hold_q <= cpu_rdata;
      if (cpu.read_en) begin
        if (cpu_dma_reg)
          hold_q <= source_page;
        else if (cpu_ram && busy)
          hold_q <= `BLOCKED_READ;
        else if (in_wram(cpu.addr))
          wram_pend_q <= 1'b1;
        else if (in_oam(cpu.addr))
          oam_pend_q <= 1'b1;
        else
          hold_q <= `OPEN_BUS;
      end
      // region of the dma read one cycle back
      dma_wram_hit_q <= busy && wram_req.read_en;
      dma_oam_hit_q  <= busy && oam_req.read_en;
    end
  end

  assign cpu_rdata = wram_pend_q ? wram_rdata : (oam_pend_q ? oam_rdata : hold_q);
  // unmapped source page copies ff
  assign dma_rdata = dma_wram_hit_q ? wram_rdata :
                     (dma_oam_hit_q ? oam_rdata : `BLOCKED_READ);

endmodule

// ==== design/oam_dma_top.sv ====
`timescale 1ns/100ps

`include "oam_dma_macros.svh"

module oam_dma_top (
  input  logic              clk,
  input  logic              reset,
  input  bus_pkg::cpu_req_t cpu,
  output logic [7:0]        cpu_rdata,
  output logic              busy
);

  // engine to arbiter
  logic              start;
  logic [7:0]        start_page;
  logic [7:0]        source_page;
  bus_pkg::mem_req_t dma_req;
  logic [7:0]        dma_rdata;

  // arbiter to rams
  bus_pkg::mem_req_t wram_req;
  logic [7:0]        wram_rdata;
  bus_pkg::mem_req_t oam_req;
  logic [7:0]        oam_rdata;

  // ==========================================================
  // dma engine and arbiter
  // ==========================================================
  oam_dma_engine i_engine (
    .clk, .reset, .start, .start_page, .source_page, .busy, .dma_req, .dma_rdata
  );

  mem_arbiter i_arbiter (
    .clk, .reset, .cpu, .cpu_rdata, .start, .start_page, .source_page, .busy,
    .dma_req, .dma_rdata, .wram_req, .wram_rdata, .oam_req, .oam_rdata
  );

  // ==========================================================
  // memories
  // ==========================================================
  // 8 KiB work ram
  byte_ram #(.ADDR_BITS(`WRAM_ADDR_BITS)) i_wram (.clk, .req(wram_req), .rdata(wram_rdata));

  // 256 byte oam, only 160 mapped
  byte_ram #(.ADDR_BITS(`OAM_ADDR_BITS)) i_oam (.clk, .req(oam_req), .rdata(oam_rdata));

endmodule

// ==== bench/oam_dma_tb.sv ====
`timescale 1ns/100ps

`include "oam_dma_macros.svh"

module oam_dma_tb;

  localparam int TRANSFERS   = 4;
  localparam int ACCESSES    = 1010;
  localparam int PARTWAY     = 100;
  localparam int XFER_CYCLES = 640;
  // transfers plus cpu traffic, doubled for margin
  localparam int WATCHDOG_CYCLES =
    2 * (TRANSFERS * XFER_CYCLES + ACCESSES * 2 + PARTWAY + 200);

  logic              clk;
  logic              reset;
  bus_pkg::cpu_req_t cpu;
  logic [7:0]        cpu_rdata;
  logic              busy;

  // reference model
  logic [31:0] lfsr_state;
  logic [7:0]  wram_model [8192];
  logic [7:0]  oam_model [160];
  int          data_errors;
  int          timing_errors;

  // busy length tracking
  logic        dma_write;
  logic [10:0] busy_len;

  oam_dma_top i_dut (.clk, .reset, .cpu, .cpu_rdata, .busy);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  // ==========================================================
  // busy timing
  // ==========================================================
  assign dma_write = cpu.write_en && (cpu.addr == `DMA_REG_ADDR);

  // sampled busy cycles since the last register write
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy_len <= 11'd0;
    end else if (dma_write) begin
      busy_len <= 11'd0;
    end else if (busy) begin
      busy_len <= busy_len + 11'd1;
    end
  end

  task automatic timing_fail(input string what);
    timing_errors++;
    $display("timing failure at %0t ns: %s", $time, what);
  endtask

  busy_rise: assert property (@(posedge clk) disable iff (reset) dma_write |=> busy)
    else timing_fail("busy did not rise the cycle after the register write");
  busy_cause: assert property (@(posedge clk) disable iff (reset) $rose(busy) |-> $past(dma_write))
    else timing_fail("busy rose without a register write");
  busy_bound: assert property (@(posedge clk) disable iff (reset)
    busy && !dma_write |-> busy_len < 11'(XFER_CYCLES))
    else timing_fail("busy stayed high past the transfer length");
  busy_length: assert property (@(posedge clk) disable iff (reset)
    $fell(busy) |-> busy_len == 11'(XFER_CYCLES))
    else timing_fail("busy fell before the transfer length");

  // ==========================================================
  // stimulus helpers
  // ==========================================================
  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] random_byte();
    logic [7:0] b;
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
    return b;
  endfunction

  // pages C0 to DF are work ram, anything else copies ff
  function automatic logic [7:0] source_byte(input logic [7:0] page, input logic [7:0] offset);
    if ((page >= 8'hC0) && (page <= 8'hDF))
      return wram_model[{page[4:0], offset}];
    return `BLOCKED_READ;
  endfunction

  task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
    @(posedge clk);
    cpu.addr     <= addr;
    cpu.wdata    <= data;
    cpu.read_en  <= 1'b0;
    cpu.write_en <= 1'b1;
    @(posedge clk);
    cpu.write_en <= 1'b0;
  endtask

  task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
    @(posedge clk);
    cpu.addr     <= addr;
    cpu.read_en  <= 1'b1;
    cpu.write_en <= 1'b0;
    @(posedge clk);
    cpu.read_en <= 1'b0;
    // registered data, mid cycle after the strobe edge
    @(negedge clk);
    data = cpu_rdata;
  endtask

  task automatic check_read(input string name, input logic [15:0] addr,
                            input logic [7:0] expected);
    logic [7:0] actual;
    cpu_read(addr, actual);
    assert (actual === expected) else begin
      data_errors++;
      $display("mismatch %s addr %h: expected %h, actual %h", name, addr, expected, actual);
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (busy && (cycles < XFER_CYCLES + 64)) begin
      @(negedge clk);
      cycles++;
    end
    if (busy)
      timing_fail("busy did not fall after a full transfer time");
  endtask

  task automatic fill_page(input logic [7:0] page);
    logic [7:0]  value;
    logic [15:0] addr;
    for (int i = 0; i < 256; i++) begin
      value = random_byte();
      addr  = {page, i[7:0]};
      wram_model[addr[12:0]] = value;
      cpu_write(addr, value);
    end
  endtask

  task automatic model_transfer(input logic [7:0] page);
    for (int j = 0; j < int'(`OAM_LEN); j++)
      oam_model[j] = source_byte(page, j[7:0]);
  endtask

  task automatic check_oam(input string name);
    for (int j = 0; j < int'(`OAM_LEN); j++)
      check_read(name, `OAM_BASE + {8'h00, j[7:0]}, oam_model[j]);
  endtask

  // ==========================================================
  // test sequence
  // ==========================================================
  initial begin
    cpu           = '0;
    reset         = 1'b1;
    lfsr_state    = 32'h7054;
    data_errors   = 0;
    timing_errors = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // reset state, register, open bus
    @(negedge clk);
    assert (busy === 1'b0) else begin
      data_errors++;
      $display("mismatch reset busy: expected 0, actual %b", busy);
    end
    check_read("reset register", `DMA_REG_ADDR, 8'h00);
    check_read("open bus", 16'h8000, `OPEN_BUS);

    // source pages
    fill_page(8'hC1);
    fill_page(8'hD0);

    // full copy from C1
    cpu_write(`DMA_REG_ADDR, 8'hC1);
    model_transfer(8'hC1);
    check_read("register readback", `DMA_REG_ADDR, 8'hC1);
    wait_idle();
    check_read("register after copy", `DMA_REG_ADDR, 8'hC1);
    check_oam("full copy");

    // lock-out during an unmapped source transfer
    cpu_write(`DMA_REG_ADDR, 8'h40);
    model_transfer(8'h40);
    check_read("wram locked", 16'hC105, `BLOCKED_READ);
    check_read("oam locked", 16'hFE10, `BLOCKED_READ);
    // byte 0 already copied, these writes go nowhere
    cpu_write(16'hFE00, 8'h5A);
    cpu_write(16'hC133, ~wram_model[13'h0133]);
    wait_idle();
    check_read("dropped oam write", 16'hFE00, oam_model[0]);
    check_read("dropped wram write", 16'hC133, wram_model[13'h0133]);
    check_oam("unmapped source");

    // restart partway through
    cpu_write(`DMA_REG_ADDR, 8'hC1);
    repeat (PARTWAY) @(posedge clk);
    cpu_write(`DMA_REG_ADDR, 8'hD0);
    model_transfer(8'hD0);
    wait_idle();
    check_oam("restart");

    $display("data errors: %0d, timing errors: %0d", data_errors, timing_errors);
    if ((data_errors == 0) && (timing_errors == 0))
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== oam_dma.f ====
+incdir+design
design/bus_pkg.sv
design/dma_pkg.sv
design/byte_ram.sv
design/oam_dma_engine.sv
design/mem_arbiter.sv
design/oam_dma_top.sv
bench/oam_dma_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the oam dma testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module oam_dma_tb -f oam_dma.f \
  || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Voam_dma_tb)"
echo "$sim_out"

echo "$sim_out" | grep -qx "NO ERRORS" && exit 0 || exit 1
